// File: verilog/scorePkg.sv
`default_nettype none

package scorePkg;

    //////////////////////////////////////////////////
    // Score limits
    //////////////////////////////////////////////////

    // Seven bits hold 0 to 99
    localparam int scoreWidth = 7;
    // Scores stop here
    localparam int scoreMax = 99;

    //////////////////////////////////////////////////
    // Link buffering
    //////////////////////////////////////////////////

    // FIFO entries, also the keeper's credits after reset
    localparam int fifoDepth = 4;
    // Must hold the full count, so one extra value
    localparam int creditWidth = $clog2(fifoDepth + 1);
    // Index into the FIFO store
    localparam int fifoPtrWidth = $clog2(fifoDepth);

    // One link word, read by the isControl flag
    typedef union packed {
        // Score snapshot
        struct packed {
            logic [scoreWidth-1:0] scoreA;
            logic [scoreWidth-1:0] scoreB;
        } scores;
        // Blanking command
        struct packed {
            logic                      blank;
            logic [2*scoreWidth-2:0]   reserved;
        } control;
    } scoreWord;

endpackage

`default_nettype wire

// File: verilog/displayPkg.sv
`default_nettype none

package displayPkg;

    // Four digits: A tens, A ones, B tens, B ones
    localparam int digitCount = 4;
    // Bits that select one digit
    localparam int positionWidth = $clog2(digitCount);

    // Segments are active low, all off
    localparam logic [6:0] segBlank = 7'b1111111;

    // Enables per position, active low
    // Position 0 is leftmost, so bit 3 goes low first
    localparam logic [digitCount-1:0][digitCount-1:0] digitEnable = {
        4'b1110,
        4'b1101,
        4'b1011,
        4'b0111
    };

    // BCD digit to segments, bit 0 is segment a, bit 6 is g
    function automatic logic [6:0] segmentsOf(input logic [3:0] digit);
        case (digit)
            4'd0: return 7'b1000000;
            4'd1: return 7'b1111001;
            4'd2: return 7'b0100100;
            4'd3: return 7'b0110000;
            4'd4: return 7'b0011001;
            4'd5: return 7'b0010010;
            4'd6: return 7'b0000010;
            4'd7: return 7'b1111000;
            4'd8: return 7'b0000000;
            4'd9: return 7'b0010000;
            // Not a BCD digit, keep dark
            default: return segBlank;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verilog/scoreLinkIf.sv
`timescale 1ns/100ps
`default_nettype none

// Credit-based link, no ready: the receiver always takes a valid beat
interface scoreLinkIf;
    import scorePkg::*;

    // Beat present this cycle
    logic     valid;
    // Selects the control view of word
    logic     isControl;
    // Snapshot or blanking command
    scoreWord word;
    // One pulse per freed receiver slot
    logic     creditReturn;

    modport sender (
        output valid,
        output isControl,
        output word,
        input  creditReturn
    );

    modport receiver (
        input  valid,
        input  isControl,
        input  word,
        output creditReturn
    );

endinterface

`default_nettype wire

// File: verilog/scoreKeeper.sv
`timescale 1ns/100ps
`default_nettype none

module scoreKeeper (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        pointA,
    input  logic        pointB,
    input  logic        clear,
    input  logic        blank,
    scoreLinkIf.sender  link
);
    import scorePkg::*;

    // Live scores
    logic [scoreWidth-1:0]  scoreA;
    logic [scoreWidth-1:0]  scoreB;
    // Last snapshot that went out
    logic [scoreWidth-1:0]  sentA;
    logic [scoreWidth-1:0]  sentB;
    logic                   sentBlank;
    // Free FIFO slots
    logic [creditWidth-1:0] credits;
    logic                   blankChanged;
    logic                   scoresChanged;

    //////////////////////////////////////////////////
    // Score counting
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            scoreA <= '0;
            scoreB <= '0;
        end else if (clear) begin
            // Clear beats any point in the same cycle
            scoreA <= '0;
            scoreB <= '0;
        end else begin
            // Saturate at the limit
            if (pointA && scoreA != scoreWidth'(scoreMax))
                scoreA <= scoreA + 1'b1;
            if (pointB && scoreB != scoreWidth'(scoreMax))
                scoreB <= scoreB + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Sending
    //////////////////////////////////////////////////

    assign blankChanged  = blank != sentBlank;
    assign scoresChanged = (scoreA != sentA) || (scoreB != sentB);

    always_comb begin
        link.word      = '0;
        // Only while a credit is held
        link.valid     = (credits != '0) && (blankChanged || scoresChanged);
        // Blank change goes first
        link.isControl = blankChanged;
        if (blankChanged) begin
            link.word.control.blank = blank;
        end else begin
            link.word.scores.scoreA = scoreA;
            link.word.scores.scoreB = scoreB;
        end
    end

    // Held changes merge, only the newest values are compared
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            sentA     <= '0;
            sentB     <= '0;
            sentBlank <= 1'b0;
        end else if (link.valid) begin
            if (link.isControl) begin
                sentBlank <= blank;
            end else begin
                sentA <= scoreA;
                sentB <= scoreB;
            end
        end
    end

    // Spend on send, earn on return
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            credits <= creditWidth'(fifoDepth);
        end else begin
            case ({link.valid, link.creditReturn})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/scoreFifo.sv
`timescale 1ns/100ps
`default_nettype none

module scoreFifo (
    input  logic          Clk,
    input  logic          rstN,
    scoreLinkIf.receiver  upLink,
    scoreLinkIf.sender    downLink
);
    import scorePkg::*;

    // Record store and its control flags
    scoreWord               wordMem [fifoDepth];
    logic                   ctlMem  [fifoDepth];
    logic [fifoPtrWidth-1:0] wrPtr;
    logic [fifoPtrWidth-1:0] rdPtr;
    // Entries held
    logic [creditWidth-1:0] count;
    // Scanner has one pending slot
    logic [creditWidth-1:0] downCredits;

    // Written data has no reset
    always_ff @(posedge Clk) begin
        if (upLink.valid) begin
            wordMem[wrPtr] <= upLink.word;
            ctlMem[wrPtr]  <= upLink.isControl;
        end
    end

    // Head goes out when present and the scanner has room
    assign downLink.valid     = (count != '0) && (downCredits != '0);
    assign downLink.word      = wordMem[rdPtr];
    assign downLink.isControl = ctlMem[rdPtr];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (upLink.valid)
                wrPtr <= (wrPtr == fifoPtrWidth'(fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (downLink.valid)
                rdPtr <= (rdPtr == fifoPtrWidth'(fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            // No overflow, upstream credits equal depth
            count <= count + creditWidth'(upLink.valid) - creditWidth'(downLink.valid);
        end
    end

    // Downstream credit counter
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            downCredits <= creditWidth'(1);
        end else begin
            case ({downLink.valid, downLink.creditReturn})
                2'b10:   downCredits <= downCredits - 1'b1;
                2'b01:   downCredits <= downCredits + 1'b1;
                default: downCredits <= downCredits;
            endcase
        end
    end

    // Freed slot goes back one cycle after the entry leaves
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN)
            upLink.creditReturn <= 1'b0;
        else
            upLink.creditReturn <= downLink.valid;
    end

endmodule

`default_nettype wire

// File: verilog/binToBcd2.sv
`timescale 1ns/100ps
`default_nettype none

// Two BCD digits for 0 to 99
module binToBcd2 (
    input  logic [6:0] bin,
    output logic [3:0] tens,
    output logic [3:0] ones
);

    // Largest multiple of ten not above bin
    logic [6:0] tensBase;

    always_comb begin
        tens     = '0;
        tensBase = '0;
        // Compare with 10 .. 90, last hit wins
        for (int t = 1; t <= 9; t++) begin
            if (bin >= 7'(10 * t)) begin
                tens     = 4'(t);
                tensBase = 7'(10 * t);
            end
        end
        // Remainder is below ten
        ones = 4'(bin - tensBase);
    end

endmodule

`default_nettype wire

// File: verilog/displayScanner.sv
`timescale 1ns/100ps
`default_nettype none

module displayScanner #(
    parameter int scanPrescale = 16
) (
    input  logic                              Clk,
    input  logic                              rstN,
    scoreLinkIf.receiver                      link,
    output logic [6:0]                        seg7,
    output logic [displayPkg::digitCount-1:0] digitEn,
    output logic                              dp
);
    import scorePkg::*;
    import displayPkg::*;

    // Free-running scan, top bits pick the digit
    logic [scanPrescale+positionWidth-1:0] scanCnt;
    logic [positionWidth-1:0]              position;
    // Last cycle of position 3
    logic                                  frameEnd;

    // Pending slot
    logic     pendValid;
    logic     pendControl;
    scoreWord pendWord;

    // What the frame shows
    logic [scoreWidth-1:0] shownA;
    logic [scoreWidth-1:0] shownB;
    logic                  shownBlank;

    // Digits in scan order, 0 is A tens
    logic [digitCount-1:0][3:0] digits;

    //////////////////////////////////////////////////
    // Scan timing
    //////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN)
            scanCnt <= '0;
        else
            scanCnt <= scanCnt + 1'b1;
    end

    assign position = scanCnt[scanPrescale+positionWidth-1 -: positionWidth];
    assign frameEnd = &scanCnt;

    //////////////////////////////////////////////////
    // Record intake
    //////////////////////////////////////////////////

    // Payload has no reset
    always_ff @(posedge Clk) begin
        if (link.valid) begin
            pendWord    <= link.word;
            pendControl <= link.isControl;
        end
    end

    // Single credit: a new beat only lands while the slot is empty
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pendValid  <= 1'b0;
            shownA     <= '0;
            shownB     <= '0;
            shownBlank <= 1'b0;
        end else begin
            if (frameEnd && pendValid) begin
                pendValid <= 1'b0;
                // Decode by the flag through one view or the other
                if (pendControl) begin
                    shownBlank <= pendWord.control.blank;
                end else begin
                    shownA <= pendWord.scores.scoreA;
                    shownB <= pendWord.scores.scoreB;
                end
            end
            if (link.valid)
                pendValid <= 1'b1;
        end
    end

    // Slot frees at the frame boundary
    assign link.creditReturn = frameEnd && pendValid;

    //////////////////////////////////////////////////
    // Digit drive
    //////////////////////////////////////////////////

    binToBcd2 iBcdA (
        .bin  (shownA),
        .tens (digits[0]),
        .ones (digits[1])
    );

    binToBcd2 iBcdB (
        .bin  (shownB),
        .tens (digits[2]),
        .ones (digits[3])
    );

    always_comb begin
        if (shownBlank) begin
            // Whole display dark
            digitEn = '1;
            seg7    = segBlank;
        end else begin
            digitEn = digitEnable[position];
            seg7    = segmentsOf(digits[position]);
        end
    end

    // Decimal point stays off
    assign dp = 1'b1;

endmodule

`default_nettype wire

// File: verilog/scoreboardTop.sv
`timescale 1ns/100ps
`default_nettype none

module scoreboardTop #(
    // Cycles per digit are 2**scanPrescale
    parameter int scanPrescale = 16
) (
    input  logic       Clk,
    input  logic       rstN,
    input  logic       pointA,
    input  logic       pointB,
    input  logic       clear,
    input  logic       blank,
    output logic [6:0] seg7,
    output logic [3:0] digitEn,
    output logic       dp
);

    // Keeper to FIFO, and FIFO to scanner
    scoreLinkIf keeperLink ();
    scoreLinkIf displayLink ();

    // Producer
    scoreKeeper iKeeper (
        .Clk    (Clk),
        .rstN   (rstN),
        .pointA (pointA),
        .pointB (pointB),
        .clear  (clear),
        .blank  (blank),
        .link   (keeperLink.sender)
    );

    // Buffer
    scoreFifo iFifo (
        .Clk      (Clk),
        .rstN     (rstN),
        .upLink   (keeperLink.receiver),
        .downLink (displayLink.sender)
    );

    // Consumer
    displayScanner #(
        .scanPrescale (scanPrescale)
    ) iScanner (
        .Clk     (Clk),
        .rstN    (rstN),
        .link    (displayLink.receiver),
        .seg7    (seg7),
        .digitEn (digitEn),
        .dp      (dp)
    );

endmodule

`default_nettype wire

// File: verification/scoreboardTb.sv
`timescale 1ns/100ps
`default_nettype none

module scoreboardTb;
    import scorePkg::*;
    import displayPkg::*;

    // Short scan so frames pass quickly
    localparam int scanPrescale = 2;
    localparam int slotCycles   = 2 ** scanPrescale;
    localparam int frameCycles  = slotCycles * digitCount;

    logic                  Clk;
    logic                  rstN;
    logic                  pointA;
    logic                  pointB;
    logic                  clear;
    logic                  blank;
    logic [6:0]            seg7;
    logic [digitCount-1:0] digitEn;
    logic                  dp;

    integer seed;
    // Reference scores
    logic [scoreWidth-1:0]   modelA;
    logic [scoreWidth-1:0]   modelB;
    // Model scores after every driven cycle, as {A, B}
    logic [2*scoreWidth-1:0] history [$];
    // Earliest history entry the display may still show
    int                      histIdx;
    logic                    burstDone;
    // Segments of the last captured frame, in scan order
    logic [6:0]              frameSeg [digitCount];

    scoreboardTop #(
        .scanPrescale (scanPrescale)
    ) i_dut (
        .Clk     (Clk),
        .rstN    (rstN),
        .pointA  (pointA),
        .pointB  (pointB),
        .clear   (clear),
        .blank   (blank),
        .seg7    (seg7),
        .digitEn (digitEn),
        .dp      (dp)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkScores(input string testName,
                               input logic [scoreWidth-1:0] expA,
                               input logic [scoreWidth-1:0] expB,
                               input logic [scoreWidth-1:0] actA,
                               input logic [scoreWidth-1:0] actB);
        if (expA !== actA || expB !== actB)
            reportFailure($sformatf("Error %s: expected scores %0d %0d, actual %0d %0d",
                                    testName, expA, expB, actA, actB));
    endtask

    task automatic checkSegments(input string testName,
                                 input logic [6:0] expSeg,
                                 input logic [6:0] actSeg);
        if (expSeg !== actSeg)
            reportFailure($sformatf("Error %s: expected seg7 %b, actual %b",
                                    testName, expSeg, actSeg));
    endtask

    // Digit shown by a pattern, -1 if none
    function automatic int decodeDigit(input logic [6:0] seg);
        decodeDigit = -1;
        for (int d = 0; d <= 9; d++)
            if (segmentsOf(4'(d)) === seg)
                decodeDigit = d;
    endfunction

    // Scan position selected by an enable pattern
    function automatic int positionOf(input logic [digitCount-1:0] en);
        positionOf = -1;
        for (int p = 0; p < digitCount; p++)
            if (en === digitEnable[p])
                positionOf = p;
    endfunction

    function automatic logic [scoreWidth-1:0] shownValue(input logic [6:0] tensSeg,
                                                         input logic [6:0] onesSeg);
        return scoreWidth'(decodeDigit(tensSeg) * 10 + decodeDigit(onesSeg));
    endfunction

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Inputs change just after the rising edge
    task automatic tick();
        @(posedge Clk);
        #10;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            tick();
            pointA = 1'b0;
            pointB = 1'b0;
            clear  = 1'b0;
        end
    endtask

    // One cycle of pulses, model follows with clear first and saturation
    task automatic drivePulses(input logic a, input logic b, input logic c);
        tick();
        pointA = a;
        pointB = b;
        clear  = c;
        if (c) begin
            modelA = '0;
            modelB = '0;
        end else begin
            if (a && modelA != scoreWidth'(scoreMax))
                modelA = modelA + 1'b1;
            if (b && modelB != scoreWidth'(scoreMax))
                modelB = modelB + 1'b1;
        end
        history.push_back({modelA, modelB});
    endtask

    //////////////////////////////////////////////////
    // Display monitor
    //////////////////////////////////////////////////

    // Aligns to a frame start, then samples each slot in its middle
    task automatic captureFrame(input string testName);
        int waited;
        int pos;
        waited = 0;
        @(negedge Clk);
        while (digitEn !== digitEnable[digitCount-1]) begin
            waited++;
            if (waited > 2 * frameCycles)
                reportFailure($sformatf("%s: timed out waiting for the last digit", testName));
            @(negedge Clk);
        end
        waited = 0;
        while (digitEn !== digitEnable[0]) begin
            waited++;
            if (waited > 2 * frameCycles)
                reportFailure($sformatf("%s: timed out waiting for a frame start", testName));
            @(negedge Clk);
        end
        // First cycle of slot 0, move to its middle
        repeat (slotCycles / 2) @(negedge Clk);
        for (int p = 0; p < digitCount; p++) begin
            if (p > 0)
                repeat (slotCycles) @(negedge Clk);
            pos = positionOf(digitEn);
            if (pos != p)
                reportFailure($sformatf("Error %s: expected digit position %0d, actual %0d",
                                        testName, p, pos));
            if (dp !== 1'b1)
                reportFailure($sformatf("%s: decimal point is lit", testName));
            frameSeg[p] = seg7;
        end
    endtask

    // Captured frame against the model scores
    task automatic checkFrame(input string testName);
        logic [3:0] expDigits [digitCount];
        expDigits[0] = 4'(modelA / 10);
        expDigits[1] = 4'(modelA % 10);
        expDigits[2] = 4'(modelB / 10);
        expDigits[3] = 4'(modelB % 10);
        checkScores(testName, modelA, modelB,
                    shownValue(frameSeg[0], frameSeg[1]),
                    shownValue(frameSeg[2], frameSeg[3]));
        for (int p = 0; p < digitCount; p++)
            checkSegments($sformatf("%s digit %0d", testName, p),
                          segmentsOf(expDigits[p]), frameSeg[p]);
    endtask

    // Quiet for more than three frames
    task automatic settleAndCheck(input string testName);
        idle(3 * frameCycles + slotCycles);
        captureFrame(testName);
        checkFrame(testName);
    endtask

    // Queued records drain one per frame
    // Capture frames until the model value shows
    task automatic waitForModelFrame(input string testName, input int maxFrames);
        int frames;
        frames = 0;
        captureFrame(testName);
        while (shownValue(frameSeg[0], frameSeg[1]) !== modelA ||
               shownValue(frameSeg[2], frameSeg[3]) !== modelB) begin
            frames++;
            if (frames > maxFrames)
                checkFrame(testName);
            captureFrame(testName);
        end
        checkFrame(testName);
    endtask

    // Every frame during a burst must move forward through the history
    task automatic watchBurst();
        logic [2*scoreWidth-1:0] seen;
        int                      idx;
        while (!burstDone) begin
            captureFrame("burst");
            for (int p = 0; p < digitCount; p++)
                if (decodeDigit(frameSeg[p]) < 0)
                    reportFailure($sformatf("burst: digit %0d shows no valid pattern", p));
            seen = {shownValue(frameSeg[0], frameSeg[1]),
                    shownValue(frameSeg[2], frameSeg[3])};
            idx = histIdx;
            while (idx < history.size() && history[idx] !== seen)
                idx++;
            if (idx >= history.size())
                reportFailure($sformatf("burst: frame %0d %0d not in history from entry %0d on",
                                        seen[2*scoreWidth-1 -: scoreWidth],
                                        seen[scoreWidth-1:0], histIdx));
            histIdx = idx;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int r;
        int waited;
        seed      = 32'h7496393b;
        rstN      = 1'b0;
        pointA    = 1'b0;
        pointB    = 1'b0;
        clear     = 1'b0;
        blank     = 1'b0;
        burstDone = 1'b0;
        modelA    = '0;
        modelB    = '0;
        histIdx   = 0;
        history.push_back({modelA, modelB});
        repeat (2) @(posedge Clk);
        #10;
        rstN = 1'b1;

        // Reset display
        captureFrame("reset");
        checkFrame("reset");

        // Single points with long gaps
        repeat (6) begin
            r = $random(seed);
            drivePulses(r[0], !r[0], 1'b0);
            settleAndCheck("single points");
        end

        // Saturation, then clear against a point
        repeat (105) drivePulses(1'b1, 1'b0, 1'b0);
        idle(1);
        waitForModelFrame("saturation", 12);
        drivePulses(1'b0, 1'b1, 1'b1);
        settleAndCheck("clear");

        // Pulses every cycle, clear now and then
        histIdx = history.size() - 1;
        fork
            begin
                repeat (300) begin
                    r = $random(seed);
                    drivePulses(r[0], r[1], r[9:4] == 6'd0);
                end
                idle(1);
                burstDone = 1'b1;
            end
            watchBurst();
        join
        waitForModelFrame("burst settle", 12);

        // Blanking
        tick();
        blank  = 1'b1;
        waited = 0;
        @(negedge Clk);
        while (digitEn !== '1) begin
            waited++;
            if (waited > 3 * frameCycles)
                reportFailure("blank: display did not go dark within three frames");
            @(negedge Clk);
        end
        repeat (frameCycles) begin
            @(negedge Clk);
            if (digitEn !== '1)
                reportFailure($sformatf("Error blank: expected digitEn %b, actual %b",
                                        {digitCount{1'b1}}, digitEn));
            checkSegments("blank", segBlank, seg7);
        end
        tick();
        blank  = 1'b0;
        waited = 0;
        @(negedge Clk);
        while (digitEn === '1) begin
            waited++;
            if (waited > 3 * frameCycles)
                reportFailure("unblank: display stayed dark for three frames");
            @(negedge Clk);
        end
        captureFrame("unblank");
        checkFrame("unblank");

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: scoreboardTop.f
verilog/scorePkg.sv
verilog/displayPkg.sv
verilog/scoreLinkIf.sv
verilog/scoreKeeper.sv
verilog/scoreFifo.sv
verilog/binToBcd2.sv
verilog/displayScanner.sv
verilog/scoreboardTop.sv
verification/scoreboardTb.sv

// File: Bender.yml
package:
  name: scoreboard

sources:
  # Packages first, then the link interface
  - files:
      - verilog/scorePkg.sv
      - verilog/displayPkg.sv
      - verilog/scoreLinkIf.sv
      - verilog/scoreKeeper.sv
      - verilog/scoreFifo.sv
      - verilog/binToBcd2.sv
      - verilog/displayScanner.sv
      - verilog/scoreboardTop.sv
  - target: test
    files:
      - verification/scoreboardTb.sv
